/* hdl/alu_pipe_pkg.sv */
// Pipeline widths, ALU opcode enum, instruction word union and stage structs
package alu_pipe_pkg;

   // Datapath and register file geometry
   localparam int DATA_W   = 32;
   localparam int RF_ADR_W = 5;
   localparam int RF_WORDS = 32;
   localparam int IMM_W    = 16;
   // Shifts use only the low bits of operand B
   localparam int SHAMT_W  = 5;

   // Top bit of the opcode marks the register-immediate form
   typedef enum logic [3:0] {
      ADD  = 4'h0,
      SUB  = 4'h1,
      AND  = 4'h2,
      OR   = 4'h3,
      XOR  = 4'h4,
      SLL  = 4'h5,
      SRL  = 4'h6,
      SLT  = 4'h7,
      ADDI = 4'h8,
      ANDI = 4'h9,
      ORI  = 4'ha,
      XORI = 4'hb
   } alu_op_e;

   // Register-register word, low bits are don't care
   typedef struct packed {
      alu_op_e                              op;
      logic [RF_ADR_W-1:0]                  rd;
      logic [RF_ADR_W-1:0]                  ra;
      logic [RF_ADR_W-1:0]                  rb;
      logic [DATA_W-4-3*RF_ADR_W-1:0]       unused;
   } instr_rr_t;

   // Register-immediate word, immediate in the low half
   typedef struct packed {
      alu_op_e                              op;
      logic [RF_ADR_W-1:0]                  rd;
      logic [RF_ADR_W-1:0]                  ra;
      logic [DATA_W-4-2*RF_ADR_W-IMM_W-1:0] rsvd;
      logic signed [IMM_W-1:0]              imm;
   } instr_ri_t;

   // One issued word, read in either form
   typedef union packed {
      instr_rr_t rr;
      instr_ri_t ri;
   } instr_u;

   // Decoded instruction held between decode and execute
   typedef struct packed {
      logic                valid;
      alu_op_e             op;
      logic [RF_ADR_W-1:0] rd;
      logic [RF_ADR_W-1:0] ra;
      logic [RF_ADR_W-1:0] rb;
      logic                use_imm;
      logic [DATA_W-1:0]   imm;
   } dec_stage_t;

   // Instruction in execute with its ALU result
   typedef struct packed {
      logic                valid;
      logic [RF_ADR_W-1:0] rd;
      logic [DATA_W-1:0]   result;
   } exe_stage_t;

   // Result carried through control and writeback
   typedef struct packed {
      logic                valid;
      logic [RF_ADR_W-1:0] rd;
      logic [DATA_W-1:0]   result;
   } wb_stage_t;

endpackage

/* hdl/rf_ram.sv */
// Register RAM with one registered write-first read port and one write port
`timescale 1ns/1ps

module rf_ram (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [alu_pipe_pkg::RF_ADR_W-1:0] rd_adr_i,
   input  logic                              rd_en_i,
   output logic [alu_pipe_pkg::DATA_W-1:0]   rd_data_o,
   input  logic [alu_pipe_pkg::RF_ADR_W-1:0] wr_adr_i,
   input  logic                              wr_en_i,
   input  logic [alu_pipe_pkg::DATA_W-1:0]   wr_data_i
);
   import alu_pipe_pkg::*;

   logic [DATA_W-1:0] mem [RF_WORDS];
   logic [DATA_W-1:0] rd_data_q;
   // Set when the last read targeted r0
   logic              rd_zero_q;

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_adr_i] <= wr_data_i;
      end
   end

   // Registered read, a same-edge write to the read address wins
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         if (wr_en_i && (wr_adr_i == rd_adr_i)) begin
            rd_data_q <= wr_data_i;
         end else begin
            rd_data_q <= mem[rd_adr_i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_zero_q <= 1'b1;
      end else if (rd_en_i) begin
         rd_zero_q <= (rd_adr_i == '0);
      end
   end

   // r0 is never stored, its read is forced to zero
   assign rd_data_o = rd_zero_q ? '0 : rd_data_q;

   a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
      wr_en_i |-> (wr_adr_i != '0));

endmodule

/* hdl/rf_bypass.sv */
// Register file with two RAMs, hazard flags, saved results and operand forwarding
`timescale 1ns/1ps

module rf_bypass (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [alu_pipe_pkg::RF_ADR_W-1:0] rd_ra_adr_i,
   input  logic [alu_pipe_pkg::RF_ADR_W-1:0] rd_rb_adr_i,
   input  alu_pipe_pkg::dec_stage_t          dec_i,
   input  alu_pipe_pkg::exe_stage_t          exe_i,
   input  alu_pipe_pkg::wb_stage_t           ctrl_i,
   input  alu_pipe_pkg::wb_stage_t           wb_i,
   output logic [alu_pipe_pkg::DATA_W-1:0]   exe_rfa_o,
   output logic [alu_pipe_pkg::DATA_W-1:0]   exe_rfb_o
);
   import alu_pipe_pkg::*;

   logic [DATA_W-1:0] ram_a_data;
   logic [DATA_W-1:0] ram_b_data;
   // RAM data of the decode instruction, held through execute
   logic [DATA_W-1:0] ram_a_q;
   logic [DATA_W-1:0] ram_b_q;
   // Writeback result seen while the consumer was in decode
   logic [DATA_W-1:0] wb_saved_q;
   logic              wr_en;
   // Producer one ahead lands in control, two ahead in writeback, three ahead is saved
   logic              hz_ctrl_a;
   logic              hz_wb_a;
   logic              hz_sav_a;
   logic              hz_ctrl_b;
   logic              hz_wb_b;
   logic              hz_sav_b;

   // Source matches a live destination, r0 never matches
   function automatic logic dst_hit(input logic                valid,
                                    input logic [RF_ADR_W-1:0] dst,
                                    input logic [RF_ADR_W-1:0] src);
      dst_hit = valid && (dst == src) && (src != '0);
   endfunction

   assign wr_en = wb_i.valid && (wb_i.rd != '0);

   // Port A RAM, read with the issue-cycle address
   rf_ram rf_ram_a_inst (
      .clk       (clk),
      .rst       (rst),
      .rd_adr_i  (rd_ra_adr_i),
      .rd_en_i   (1'b1),
      .rd_data_o (ram_a_data),
      .wr_adr_i  (wb_i.rd),
      .wr_en_i   (wr_en),
      .wr_data_i (wb_i.result)
   );

   // Port B RAM, same write port
   rf_ram rf_ram_b_inst (
      .clk       (clk),
      .rst       (rst),
      .rd_adr_i  (rd_rb_adr_i),
      .rd_en_i   (1'b1),
      .rd_data_o (ram_b_data),
      .wr_adr_i  (wb_i.rd),
      .wr_en_i   (wr_en),
      .wr_data_i (wb_i.result)
   );

   // Flags taken as a valid decode instruction moves into execute
   always_ff @(posedge clk) begin
      if (rst || !dec_i.valid) begin
         hz_ctrl_a <= 1'b0;
         hz_wb_a   <= 1'b0;
         hz_sav_a  <= 1'b0;
         hz_ctrl_b <= 1'b0;
         hz_wb_b   <= 1'b0;
         hz_sav_b  <= 1'b0;
      end else begin
         hz_ctrl_a <= dst_hit(exe_i.valid, exe_i.rd, dec_i.ra);
         hz_wb_a   <= dst_hit(ctrl_i.valid, ctrl_i.rd, dec_i.ra);
         hz_sav_a  <= dst_hit(wb_i.valid, wb_i.rd, dec_i.ra);
         hz_ctrl_b <= dst_hit(exe_i.valid, exe_i.rd, dec_i.rb);
         hz_wb_b   <= dst_hit(ctrl_i.valid, ctrl_i.rd, dec_i.rb);
         hz_sav_b  <= dst_hit(wb_i.valid, wb_i.rd, dec_i.rb);
      end
   end

   // The writeback word retires at this edge, keep it for distance three
   always_ff @(posedge clk) begin
      if (dec_i.valid) begin
         wb_saved_q <= wb_i.result;
         ram_a_q    <= ram_a_data;
         ram_b_q    <= ram_b_data;
      end
   end

   // Nearest producer first, RAM last
   assign exe_rfa_o = hz_ctrl_a ? ctrl_i.result :
                      hz_wb_a   ? wb_i.result   :
                      hz_sav_a  ? wb_saved_q    :
                      ram_a_q;

   assign exe_rfb_o = hz_ctrl_b ? ctrl_i.result :
                      hz_wb_b   ? wb_i.result   :
                      hz_sav_b  ? wb_saved_q    :
                      ram_b_q;

   // A forwarded operand always belongs to a live execute instruction
   a_hz_live_exe: assert property (@(posedge clk) disable iff (rst)
      (hz_ctrl_a | hz_wb_a | hz_sav_a | hz_ctrl_b | hz_wb_b | hz_sav_b) |-> exe_i.valid);

endmodule

/* hdl/decode_stage.sv */
// Issue word decoder, RAM read address drive and decode stage register with flush
`timescale 1ns/1ps

module decode_stage (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              issue_valid_i,
   input  alu_pipe_pkg::instr_u              issue_instr_i,
   input  logic                              flush_i,
   output logic [alu_pipe_pkg::RF_ADR_W-1:0] rf_ra_adr_o,
   output logic [alu_pipe_pkg::RF_ADR_W-1:0] rf_rb_adr_o,
   output alu_pipe_pkg::dec_stage_t          dec_o
);
   import alu_pipe_pkg::*;

   dec_stage_t dec_d;
   dec_stage_t dec_q;
   logic       is_imm;

   // Opcode, rd and ra occupy the same bits in both forms
   assign is_imm = issue_instr_i.rr.op[3];

   always_comb begin
      dec_d.valid   = issue_valid_i;
      dec_d.op      = issue_instr_i.rr.op;
      dec_d.rd      = issue_instr_i.rr.rd;
      dec_d.ra      = issue_instr_i.rr.ra;
      dec_d.use_imm = is_imm;
      if (is_imm) begin
         // No B source, so no hazard can match it
         dec_d.rb  = '0;
         dec_d.imm = {{(DATA_W-IMM_W){issue_instr_i.ri.imm[IMM_W-1]}},
                      issue_instr_i.ri.imm};
      end else begin
         dec_d.rb  = issue_instr_i.rr.rb;
         dec_d.imm = '0;
      end
   end

   // RAMs sample the sources at the issue edge
   assign rf_ra_adr_o = dec_d.ra;
   assign rf_rb_adr_o = dec_d.rb;

   always_ff @(posedge clk) begin
      if (rst) begin
         dec_q.valid <= 1'b0;
      end else begin
         dec_q.valid <= dec_d.valid & ~flush_i;
      end
      dec_q.op      <= dec_d.op;
      dec_q.rd      <= dec_d.rd;
      dec_q.ra      <= dec_d.ra;
      dec_q.rb      <= dec_d.rb;
      dec_q.use_imm <= dec_d.use_imm;
      dec_q.imm     <= dec_d.imm;
   end

   // Flush hides the decode word from execute and from hazard detection
   always_comb begin
      dec_o       = dec_q;
      dec_o.valid = dec_q.valid & ~flush_i;
   end

endmodule

/* hdl/execute_alu.sv */
// Execute stage register and integer ALU
`timescale 1ns/1ps

module execute_alu (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            flush_i,
   input  alu_pipe_pkg::dec_stage_t        dec_i,
   input  logic [alu_pipe_pkg::DATA_W-1:0] rfa_i,
   input  logic [alu_pipe_pkg::DATA_W-1:0] rfb_i,
   output alu_pipe_pkg::exe_stage_t        exe_o
);
   import alu_pipe_pkg::*;

   // Decoded instruction currently in execute
   dec_stage_t         ex_q;
   logic [DATA_W-1:0]  opb;
   logic [SHAMT_W-1:0] shamt;
   logic [DATA_W-1:0]  alu_res;

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_q.valid <= 1'b0;
      end else begin
         ex_q.valid <= dec_i.valid & ~flush_i;
      end
      ex_q.op      <= dec_i.op;
      ex_q.rd      <= dec_i.rd;
      ex_q.ra      <= dec_i.ra;
      ex_q.rb      <= dec_i.rb;
      ex_q.use_imm <= dec_i.use_imm;
      ex_q.imm     <= dec_i.imm;
   end

   // Immediate replaces B in register-immediate form
   assign opb   = ex_q.use_imm ? ex_q.imm : rfb_i;
   assign shamt = opb[SHAMT_W-1:0];

   always_comb begin
      case (ex_q.op)
         ADD, ADDI: alu_res = rfa_i + opb;
         SUB:       alu_res = rfa_i - opb;
         AND, ANDI: alu_res = rfa_i & opb;
         OR, ORI:   alu_res = rfa_i | opb;
         XOR, XORI: alu_res = rfa_i ^ opb;
         SLL:       alu_res = rfa_i << shamt;
         SRL:       alu_res = rfa_i >> shamt;
         // Signed compare, result in bit 0
         SLT:       alu_res = {{(DATA_W-1){1'b0}}, ($signed(rfa_i) < $signed(opb))};
         default:   alu_res = '0;
      endcase
   end

   assign exe_o.valid  = ex_q.valid;
   assign exe_o.rd     = ex_q.rd;
   assign exe_o.result = alu_res;

   a_op_known: assert property (@(posedge clk) disable iff (rst)
      ex_q.valid |-> (ex_q.op inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SLT,
                                       ADDI, ANDI, ORI, XORI}));

endmodule

/* hdl/ctrl_wb_stage.sv */
// Control and writeback stage registers feeding the register file write port
`timescale 1ns/1ps

module ctrl_wb_stage (
   input  logic                     clk,
   input  logic                     rst,
   input  alu_pipe_pkg::exe_stage_t exe_i,
   output alu_pipe_pkg::wb_stage_t  ctrl_o,
   output alu_pipe_pkg::wb_stage_t  wb_o
);
   import alu_pipe_pkg::*;

   wb_stage_t ctrl_q;
   wb_stage_t wb_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_q.valid <= 1'b0;
         wb_q.valid   <= 1'b0;
      end else begin
         // Results for r0 are dropped here and never forwarded or written
         ctrl_q.valid <= exe_i.valid & (exe_i.rd != '0);
         wb_q.valid   <= ctrl_q.valid;
      end
      ctrl_q.rd     <= exe_i.rd;
      ctrl_q.result <= exe_i.result;
      wb_q.rd       <= ctrl_q.rd;
      wb_q.result   <= ctrl_q.result;
   end

   assign ctrl_o = ctrl_q;
   // Writeback word doubles as the RAM write port
   assign wb_o   = wb_q;

endmodule

/* hdl/alu_pipe_top.sv */
// Pipeline top level connecting decode, register file, execute and writeback
`timescale 1ns/1ps

module alu_pipe_top (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              issue_valid_i,
   input  alu_pipe_pkg::instr_u              issue_instr_i,
   input  logic                              flush_i,
   output logic                              wb_valid_o,
   output logic [alu_pipe_pkg::RF_ADR_W-1:0] wb_rd_o,
   output logic [alu_pipe_pkg::DATA_W-1:0]   wb_data_o
);
   import alu_pipe_pkg::*;

   logic [RF_ADR_W-1:0] rf_ra_adr;
   logic [RF_ADR_W-1:0] rf_rb_adr;
   dec_stage_t          dec;
   exe_stage_t          exe;
   wb_stage_t           ctrl;
   wb_stage_t           wb;
   logic [DATA_W-1:0]   exe_rfa;
   logic [DATA_W-1:0]   exe_rfb;

   decode_stage decode_stage_inst (
      .clk           (clk),
      .rst           (rst),
      .issue_valid_i (issue_valid_i),
      .issue_instr_i (issue_instr_i),
      .flush_i       (flush_i),
      .rf_ra_adr_o   (rf_ra_adr),
      .rf_rb_adr_o   (rf_rb_adr),
      .dec_o         (dec)
   );

   rf_bypass rf_bypass_inst (
      .clk         (clk),
      .rst         (rst),
      .rd_ra_adr_i (rf_ra_adr),
      .rd_rb_adr_i (rf_rb_adr),
      .dec_i       (dec),
      .exe_i       (exe),
      .ctrl_i      (ctrl),
      .wb_i        (wb),
      .exe_rfa_o   (exe_rfa),
      .exe_rfb_o   (exe_rfb)
   );

   execute_alu execute_alu_inst (
      .clk     (clk),
      .rst     (rst),
      .flush_i (flush_i),
      .dec_i   (dec),
      .rfa_i   (exe_rfa),
      .rfb_i   (exe_rfb),
      .exe_o   (exe)
   );

   ctrl_wb_stage ctrl_wb_stage_inst (
      .clk    (clk),
      .rst    (rst),
      .exe_i  (exe),
      .ctrl_o (ctrl),
      .wb_o   (wb)
   );

   // Retiring instruction
   assign wb_valid_o = wb.valid;
   assign wb_rd_o    = wb.rd;
   assign wb_data_o  = wb.result;

endmodule

/* verification/alu_pipe_tb.sv */
// Directed tests for the forwarding ALU pipeline with a reference register model
`timescale 1ns/1ps

module alu_pipe_tb;
   import alu_pipe_pkg::*;

   localparam int CLK_PERIOD     = 40;
   localparam int LATENCY        = 4;
   localparam int DRAIN_LIMIT    = 10;
   localparam int RAND_WORDS     = 200;
   localparam int RAND_MAX_GAP   = 3;
   // Directed words are spaced at most five cycles apart
   localparam int DIRECTED_WORDS = 140;
   localparam int TIMEOUT_CYCLES = DIRECTED_WORDS * 5 + RAND_WORDS * (RAND_MAX_GAP + 1)
                                   + 8 * DRAIN_LIMIT + 20;
   localparam logic [31:0] LFSR_SEED = 32'd88013;
   localparam logic [31:0] LFSR_TAPS = 32'hb4bcd35c;

   // One expected retirement
   typedef struct packed {
      logic [RF_ADR_W-1:0] rd;
      logic [DATA_W-1:0]   data;
      logic [31:0]         cycle;
   } exp_t;

   logic                clk;
   logic                rst;
   logic                issue_valid_i;
   instr_u              issue_instr_i;
   logic                flush_i;
   logic                wb_valid_o;
   logic [RF_ADR_W-1:0] wb_rd_o;
   logic [DATA_W-1:0]   wb_data_o;

   logic [DATA_W-1:0]   model [RF_WORDS];
   exp_t                exp_q [$];
   logic [31:0]         cyc = '0;
   logic [31:0]         lfsr_q;

   alu_pipe_top alu_pipe_top_inst (
      .clk           (clk),
      .rst           (rst),
      .issue_valid_i (issue_valid_i),
      .issue_instr_i (issue_instr_i),
      .flush_i       (flush_i),
      .wb_valid_o    (wb_valid_o),
      .wb_rd_o       (wb_rd_o),
      .wb_data_o     (wb_data_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Cycle count is read on the falling edge only
   always @(posedge clk) cyc <= cyc + 1;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL at time %0t: %s got %h expected %h",
                                 $time, name, got, exp));
      end
   endtask

   // Galois LFSR stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
      end
      return v;
   endfunction

   function automatic alu_op_e op_at(input int k);
      case (k)
         0:       return ADD;
         1:       return SUB;
         2:       return AND;
         3:       return OR;
         4:       return XOR;
         5:       return SLL;
         6:       return SRL;
         7:       return SLT;
         8:       return ADDI;
         9:       return ANDI;
         10:      return ORI;
         default: return XORI;
      endcase
   endfunction

   function automatic instr_u rr_word(input alu_op_e op, input int rd, input int ra,
                                      input int rb);
      instr_u w;
      w.rr.op     = op;
      w.rr.rd     = 5'(rd);
      w.rr.ra     = 5'(ra);
      w.rr.rb     = 5'(rb);
      w.rr.unused = '0;
      return w;
   endfunction

   function automatic instr_u ri_word(input alu_op_e op, input int rd, input int ra,
                                      input int imm);
      instr_u w;
      w.ri.op   = op;
      w.ri.rd   = 5'(rd);
      w.ri.ra   = 5'(ra);
      w.ri.rsvd = '0;
      w.ri.imm  = 16'(imm);
      return w;
   endfunction

   // Architectural result of one operation
   function automatic logic [31:0] ref_alu(input alu_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
      logic lt;
      // Differing signs decide by the sign of A, equal signs compare as unsigned
      lt = (a[31] != b[31]) ? a[31] : (a < b);
      case (op)
         ADD, ADDI: return a + b;
         SUB:       return a - b;
         AND, ANDI: return a & b;
         OR, ORI:   return a | b;
         XOR, XORI: return a ^ b;
         SLL:       return a << b[4:0];
         SRL:       return a >> b[4:0];
         SLT:       return {31'b0, lt};
         default:   return '0;
      endcase
   endfunction

   // Drives one word on the falling edge
   // keep is clear for words that a flush cancels
   task automatic drive_word(input instr_u w, input bit keep, input bit flush);
      exp_t                e;
      logic [31:0]         a;
      logic [31:0]         b;
      logic [RF_ADR_W-1:0] rd;
      @(negedge clk);
      issue_valid_i = 1'b1;
      issue_instr_i = w;
      flush_i       = flush;
      if (w.rr.op[3]) begin
         rd = w.ri.rd;
         a  = model[w.ri.ra];
         b  = {{16{w.ri.imm[15]}}, w.ri.imm};
      end else begin
         rd = w.rr.rd;
         a  = model[w.rr.ra];
         b  = model[w.rr.rb];
      end
      // r0 writes never retire
      if (keep && rd != 0) begin
         e.rd    = rd;
         e.data  = ref_alu(w.rr.op, a, b);
         e.cycle = cyc;
         model[rd] = e.data;
         exp_q.push_back(e);
      end
   endtask

   task automatic issue(input instr_u w);
      drive_word(w, 1'b1, 1'b0);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         issue_valid_i = 1'b0;
         issue_instr_i = '0;
         flush_i       = 1'b0;
      end
   endtask

   // Wait for every expected result, then a little longer for strays
   task automatic drain_pipe();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         if (waited == DRAIN_LIMIT) stop_on_error("Pipeline did not retire all results");
         idle_cycles(1);
         waited++;
      end
      idle_cycles(2);
   endtask

   // Writeback monitor compares register, data and latency
   always @(negedge clk) begin
      exp_t e;
      if (!rst && wb_valid_o) begin
         if (exp_q.size() == 0) begin
            stop_on_error($sformatf("Unexpected writeback to r%0d at time %0t",
                                    wb_rd_o, $time));
         end else begin
            e = exp_q.pop_front();
            check_value("wb_rd_o", 32'(wb_rd_o), 32'(e.rd));
            check_value("wb_data_o", wb_data_o, e.data);
            check_value("wb latency", cyc - e.cycle, LATENCY);
         end
      end
   end

   task automatic load_all_regs();
      for (int r = 1; r < RF_WORDS; r++) issue(ri_word(ADDI, r, 0, rand_bits(16)));
      drain_pipe();
   endtask

   // Each load reads the previous one through the RAM only
   task automatic test_no_hazard();
      for (int i = 1; i <= 8; i++) begin
         issue(ri_word(ADDI, 8 + i, 7 + i, rand_bits(16)));
         idle_cycles(4);
      end
      drain_pipe();
   endtask

   // Consumer reads port A and then port B at d words after its producer
   task automatic dist_pair(input int d);
      issue(ri_word(ADDI, 21, 1, rand_bits(16)));
      repeat (d - 1) issue(ri_word(ORI, 25, 2, rand_bits(16)));
      issue(rr_word(SUB, 22, 21, 3));
      issue(ri_word(XORI, 23, 4, rand_bits(16)));
      repeat (d - 1) issue(ri_word(ORI, 25, 2, rand_bits(16)));
      issue(rr_word(ADD, 24, 5, 23));
   endtask

   task automatic test_back_to_back_forward();
      for (int d = 1; d <= 4; d++) dist_pair(d);
      // Accumulator chain with every link at distance one
      repeat (6) issue(rr_word(ADD, 26, 26, 1));
      // Nearest of three producers in flight must win
      issue(ri_word(ADDI, 28, 0, 1));
      issue(ri_word(ADDI, 28, 0, 2));
      issue(ri_word(ADDI, 28, 0, 3));
      issue(rr_word(ADD, 29, 28, 28));
      drain_pipe();
   endtask

   task automatic test_all_ops();
      alu_op_e op;
      // Widen r1..r4 to full 32-bit operands
      issue(ri_word(ADDI, 6, 0, 16));
      for (int r = 1; r <= 4; r++) begin
         issue(rr_word(SLL, r, r, 6));
         issue(ri_word(XORI, r, r, rand_bits(16)));
      end
      // Second pass forces negative immediates
      for (int pass = 0; pass < 2; pass++) begin
         for (int k = 0; k < 12; k++) begin
            op = op_at(k);
            if (op[3]) begin
               issue(ri_word(op, 9 + k, 1 + rand_bits(2),
                             rand_bits(16) | (pass != 0 ? 32'h8000 : 32'h0)));
            end else begin
               issue(rr_word(op, 9 + k, 1 + rand_bits(2), 1 + rand_bits(2)));
            end
         end
      end
      issue(ri_word(ADDI, 7, 0, 31));
      issue(rr_word(SLL, 21, 1, 7));
      issue(rr_word(SRL, 22, 2, 7));
      // Shift amount 63 keeps only 31
      issue(ri_word(ADDI, 8, 0, 63));
      issue(rr_word(SRL, 23, 4, 8));
      issue(ri_word(ADDI, 24, 3, 'hffff));
      issue(rr_word(SLT, 25, 3, 3));
      drain_pipe();
   endtask

   task automatic test_register_zero();
      issue(ri_word(ADDI, 0, 1, 55));
      issue(rr_word(ADD, 3, 0, 0));
      issue(rr_word(ADD, 4, 2, 0));
      issue(rr_word(XOR, 0, 1, 2));
      issue(rr_word(OR, 5, 0, 0));
      issue(rr_word(SUB, 6, 0, 1));
      issue(ri_word(ADDI, 7, 0, 'hfffb));
      drain_pipe();
   endtask

   task automatic test_flush();
      issue(ri_word(ADDI, 10, 0, 100));
      issue(ri_word(ADDI, 12, 0, 200));
      drain_pipe();
      // Older word is in execute when the flush is sampled
      issue(ri_word(ADDI, 11, 0, 300));
      drive_word(ri_word(ADDI, 10, 0, 7), 1'b0, 1'b0);
      drive_word(ri_word(ADDI, 12, 0, 9), 1'b0, 1'b1);
      issue(rr_word(ADD, 13, 10, 12));
      issue(rr_word(ADD, 14, 11, 0));
      drain_pipe();
   endtask

   // Small register window keeps hazards frequent
   task automatic test_random_stream();
      alu_op_e op;
      for (int n = 0; n < RAND_WORDS; n++) begin
         op = op_at(rand_bits(4) % 12);
         if (op[3]) begin
            issue(ri_word(op, rand_bits(3), rand_bits(3), rand_bits(16)));
         end else begin
            issue(rr_word(op, rand_bits(3), rand_bits(3), rand_bits(3)));
         end
         idle_cycles(rand_bits(2));
      end
      drain_pipe();
   endtask

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      stop_on_error("Timeout, the tests ran past their cycle budget");
   end

   initial begin
      lfsr_q        = LFSR_SEED;
      rst           = 1'b1;
      issue_valid_i = 1'b0;
      issue_instr_i = '0;
      flush_i       = 1'b0;
      for (int r = 0; r < RF_WORDS; r++) model[r] = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      load_all_regs();
      test_no_hazard();
      test_back_to_back_forward();
      test_all_ops();
      test_register_zero();
      test_flush();
      test_random_stream();
      idle_cycles(4);
      if (exp_q.size() == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         stop_on_error("Expected results are still outstanding at the end");
      end
   end

endmodule

/* src.f */
hdl/alu_pipe_pkg.sv
hdl/rf_ram.sv
hdl/rf_bypass.sv
hdl/decode_stage.sv
hdl/execute_alu.sv
hdl/ctrl_wb_stage.sv
hdl/alu_pipe_top.sv
verification/alu_pipe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= alu_pipe_tb
RTL_TOP   ?= alu_pipe_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter hdl/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
